// ==== Bender.yml ====
package:
  name: rob_backend

sources:
  - uop_pkg.sv
  - rob_pkg.sv
  - rob_queue.sv
  - rob_scheduler.sv
  - phys_regfile.sv
  - alu_unit.sv
  - mul_unit.sv
  - wb_arbiter.sv
  - rob_backend_top.sv
  - target: simulation
    files:
      - tb_rob_backend.sv

// ==== alu_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_unit
  import uop_pkg::*;
  import rob_pkg::*;
(
  input  logic   clk_in,
  input  logic   rst_N_in,
  input  issue_t issue,
  input  logic   grant,
  output wb_t    result,
  output logic   busy
);

  logic [DATA_W-1:0] alu_val;

  always_comb begin
    case (issue.opcode)
      OP_ADD:  alu_val = issue.a + issue.b;
      OP_SUB:  alu_val = issue.a - issue.b;
      OP_AND:  alu_val = issue.a & issue.b;
      OP_XOR:  alu_val = issue.a ^ issue.b;
      OP_LI:   alu_val = DATA_W'(issue.imm);
      default: alu_val = '0;
    endcase
  end

  // result waiting for the bus blocks the next issue
  assign busy = result.valid && !grant;

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      result <= '0;
    end else if (!busy) begin
      result.valid   <= issue.valid;
      result.rob_ptr <= issue.rob_ptr;
      result.dest    <= issue.dest;
      result.data    <= alu_val;
    end
  end

endmodule

`default_nettype wire

// ==== mul_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module mul_unit
  import uop_pkg::*;
  import rob_pkg::*;
(
  input  logic   clk_in,
  input  logic   rst_N_in,
  input  issue_t issue,
  output wb_t    result
);

  localparam int HALF = DATA_W / 2;

  typedef struct packed {
    logic              valid;
    rob_ptr_t          rob_ptr;
    logic [PREG_W-1:0] dest;
  } tag_t;

  tag_t              s1_tag, s2_tag, s3_tag;
  logic [DATA_W-1:0] s1_lo, s1_hi;  // partial products of the two halves of b
  logic [DATA_W-1:0] s2_prod, s3_prod;

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      s1_tag <= '0;
      s2_tag <= '0;
      s3_tag <= '0;
    end else begin
      s1_tag <= '{valid: issue.valid, rob_ptr: issue.rob_ptr, dest: issue.dest};
      s2_tag <= s1_tag;
      s3_tag <= s2_tag;
    end
  end

  // only the low DATA_W bits of the product are kept
  always_ff @(posedge clk_in) begin
    s1_lo   <= issue.a * issue.b[HALF-1:0];
    s1_hi   <= issue.a * issue.b[DATA_W-1:HALF];
    s2_prod <= s1_lo + (s1_hi << HALF);
    s3_prod <= s2_prod;
  end

  assign result = '{valid: s3_tag.valid, rob_ptr: s3_tag.rob_ptr, dest: s3_tag.dest,
                    data: s3_prod};

endmodule

`default_nettype wire

// ==== phys_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module phys_regfile
  import uop_pkg::*;
  import rob_pkg::*;
#(
  parameter int NUM_PREGS = 32
) (
  input  logic                   clk_in,
  input  logic                   rst_N_in,
  input  logic [3:0][PREG_W-1:0] rd_addr,
  output logic [3:0][DATA_W-1:0] rd_data,
  output logic [3:0]             rd_ready,
  input  uop_t                   alloc,     // dispatched uop, only valid and dest matter
  input  wb_t                    wb
);

  logic [DATA_W-1:0]    regs [NUM_PREGS];
  logic [NUM_PREGS-1:0] ready;  // scoreboard

  // same-cycle writeback is forwarded to the readers
  always_comb begin
    for (int p = 0; p < 4; p++) begin
      if (wb.valid && wb.dest == rd_addr[p]) begin
        rd_data[p]  = wb.data;
        rd_ready[p] = 1'b1;
      end else begin
        rd_data[p]  = regs[rd_addr[p]];
        rd_ready[p] = ready[rd_addr[p]];
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      ready <= '1;
      for (int r = 0; r < NUM_PREGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      if (alloc.valid) begin
        ready[alloc.dest] <= 1'b0;
      end
      if (wb.valid) begin
        regs[wb.dest]  <= wb.data;
        ready[wb.dest] <= 1'b1;
      end
    end
  end

  // every writeback must follow an allocation of the same register
  a_wb_not_ready: assert property (@(posedge clk_in) disable iff (rst_N_in)
    wb.valid |-> !ready[wb.dest])
    else $error("writeback to p%0d which is already ready", wb.dest);

endmodule

`default_nettype wire

// ==== rob_backend_stim.txt ====
# U opcode dest src1 src2 imm exp_dest exp_data gap   (hex, gap 1 allows random idle cycles)
# opcode 0 add 1 sub 2 and 3 xor 4 li 5 mul; F expects rob_ready low; W n idles n cycles
U 4 01 00 00 0012 01 00000012 1
U 4 02 00 00 0034 02 00000034 1
U 4 03 00 00 00ff 03 000000ff 1
U 0 04 01 02 0000 04 00000046 1
U 1 05 01 02 0000 05 ffffffde 1
U 2 06 03 02 0000 06 00000034 1
U 3 07 03 01 0000 07 000000ed 1
W 12
U 4 08 00 00 1234 08 00001234 1
U 5 09 08 03 0000 09 001221cc 1
U 0 0a 09 04 0000 0a 00122212 1
U 4 0b 00 00 0007 0b 00000007 1
U 5 0c 0a 05 0000 0c fd97799c 1
U 3 0d 0c 0b 0000 0d fd97799b 1
W 16
U 5 0e 03 03 0000 0e 0000fe01 1
U 4 0f 00 00 0100 0f 00000100 0
U 0 10 01 03 0000 10 00000111 0
U 1 11 10 0f 0000 11 00000011 1
W 12
U 5 12 01 01 0000 12 00000144 0
U 5 13 12 12 0000 13 00019a10 0
U 5 14 13 03 0000 14 019875f0 0
U 5 15 14 02 0000 15 52f7f4c0 0
U 4 16 00 00 00aa 16 000000aa 0
U 0 17 01 01 0000 17 00000024 0
U 3 18 02 03 0000 18 000000cb 0
U 2 19 03 01 0000 19 00000012 0
U 1 1a 03 01 0000 1a 000000ed 0
F
U 0 1b 15 16 0000 1b 52f7f56a 0
U 4 1c 00 00 beef 1c 0000beef 0
U 1 1d 1c 1b 0000 1d ad08c985 1

// ==== rob_backend_top.f ====
uop_pkg.sv
rob_pkg.sv
rob_queue.sv
rob_scheduler.sv
phys_regfile.sv
alu_unit.sv
mul_unit.sv
wb_arbiter.sv
rob_backend_top.sv
tb_rob_backend.sv

// ==== rob_backend_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rob_backend_top
  import uop_pkg::*;
  import rob_pkg::*;
#(
  parameter int ROB_DEPTH = 8,
  parameter int NUM_PREGS = 32
) (
  input  logic    clk_in,
  input  logic    rst_N_in,
  input  uop_t    dispatch_in,
  output logic    rob_ready,
  output commit_t commit_out
);

  rob_entry_t [ROB_DEPTH-1:0] q_entries;
  rob_ptr_t                   q_head;
  logic [ROB_PTR_W:0]         q_count;
  logic                       q_full;
  mark_t                      alu_mark, mul_mark;
  logic                       retire;
  logic [3:0][PREG_W-1:0]     rd_addr;
  logic [3:0][DATA_W-1:0]     rd_data;
  logic [3:0]                 src_ready;
  logic                       alu_busy, alu_grant;
  issue_t                     alu_issue, mul_issue;
  wb_t                        alu_req, mul_req, wb_bus;

  assign rob_ready = !q_full;

  rob_queue #(.ROB_DEPTH(ROB_DEPTH)) u_queue (
    .clk_in(clk_in), .rst_N_in(rst_N_in), .dispatch(dispatch_in),
    .alu_mark(alu_mark), .mul_mark(mul_mark), .wb(wb_bus), .retire(retire),
    .entries_out(q_entries), .head(q_head), .count(q_count), .full(q_full)
  );

  rob_scheduler #(.ROB_DEPTH(ROB_DEPTH)) u_sched (
    .clk_in(clk_in), .rst_N_in(rst_N_in), .entries(q_entries), .head(q_head),
    .count(q_count), .rd_addr(rd_addr), .rd_data(rd_data), .src_ready(src_ready),
    .alu_busy(alu_busy), .alu_issue(alu_issue), .mul_issue(mul_issue),
    .alu_mark(alu_mark), .mul_mark(mul_mark), .retire(retire), .commit_out(commit_out)
  );

  phys_regfile #(.NUM_PREGS(NUM_PREGS)) u_prf (
    .clk_in(clk_in), .rst_N_in(rst_N_in), .rd_addr(rd_addr), .rd_data(rd_data),
    .rd_ready(src_ready), .alloc(dispatch_in), .wb(wb_bus)
  );

  alu_unit u_alu (
    .clk_in(clk_in), .rst_N_in(rst_N_in), .issue(alu_issue), .grant(alu_grant),
    .result(alu_req), .busy(alu_busy)
  );

  mul_unit u_mul (
    .clk_in(clk_in), .rst_N_in(rst_N_in), .issue(mul_issue), .result(mul_req)
  );

  wb_arbiter u_arb (
    .alu_req(alu_req), .mul_req(mul_req), .alu_grant(alu_grant), .wb_bus(wb_bus)
  );

endmodule

`default_nettype wire

// ==== rob_pkg.sv ====
`default_nettype none

package rob_pkg;

  import uop_pkg::*;

  localparam int ROB_PTR_W = 4;  // depth is limited to 16 entries

  typedef logic [ROB_PTR_W-1:0] rob_ptr_t;

  typedef enum logic [1:0] {
    ST_READY  = 2'd0,  // waiting for issue
    ST_ISSUED = 2'd1,
    ST_DONE   = 2'd2   // result captured, may commit
  } status_e;

  typedef struct packed {
    uop_t              uop;
    status_e           status;
    logic [DATA_W-1:0] result;
  } rob_entry_t;

  // scheduler to queue, moves an entry to ST_ISSUED
  typedef struct packed {
    logic     valid;
    rob_ptr_t ptr;
  } mark_t;

  typedef struct packed {
    logic              valid;
    rob_ptr_t          rob_ptr;
    opcode_e           opcode;
    logic [PREG_W-1:0] dest;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [IMM_W-1:0]  imm;
  } issue_t;

  typedef struct packed {
    logic              valid;
    rob_ptr_t          rob_ptr;
    logic [PREG_W-1:0] dest;
    logic [DATA_W-1:0] data;
  } wb_t;

  typedef struct packed {
    logic              valid;
    rob_ptr_t          rob_ptr;
    logic [PREG_W-1:0] dest;
    logic [DATA_W-1:0] data;
  } commit_t;

endpackage

`default_nettype wire

// ==== rob_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module rob_queue
  import uop_pkg::*;
  import rob_pkg::*;
#(
  parameter int ROB_DEPTH = 8
) (
  input  logic                         clk_in,
  input  logic                         rst_N_in,
  input  uop_t                         dispatch,
  input  mark_t                        alu_mark,
  input  mark_t                        mul_mark,
  input  wb_t                          wb,
  input  logic                         retire,
  output rob_entry_t [ROB_DEPTH-1:0]   entries_out,
  output rob_ptr_t                     head,
  output logic       [ROB_PTR_W:0]     count,
  output logic                         full
);

  rob_entry_t [ROB_DEPTH-1:0] ring;
  rob_ptr_t                   tail;
  logic                       push;

  assign full = (count == (ROB_PTR_W+1)'(ROB_DEPTH));
  assign push = dispatch.valid && !full;
  assign entries_out = ring;

  // pointers wrap at ROB_DEPTH, which need not be a power of two
  function automatic rob_ptr_t next_ptr(rob_ptr_t ptr);
    if (ptr == rob_ptr_t'(ROB_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= next_ptr(tail);
      end
      if (retire) begin
        head <= next_ptr(head);
      end
      case ({push, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // slots outside head..head+count are ignored downstream
  always_ff @(posedge clk_in) begin
    if (push) begin
      ring[tail].uop    <= dispatch;
      ring[tail].status <= ST_READY;
      ring[tail].result <= '0;
    end
    if (alu_mark.valid) begin
      ring[alu_mark.ptr].status <= ST_ISSUED;
    end
    if (mul_mark.valid) begin
      ring[mul_mark.ptr].status <= ST_ISSUED;
    end
    if (wb.valid) begin
      ring[wb.rob_ptr].status <= ST_DONE;
      ring[wb.rob_ptr].result <= wb.data;
    end
  end

  // the outside has to hold dispatch while rob_ready is low
  a_no_dispatch_full: assert property (@(posedge clk_in) disable iff (rst_N_in)
    dispatch.valid |-> !full)
    else $error("dispatch while reorder buffer full");

  // a unit only returns results for entries the scheduler marked earlier
  a_wb_to_issued: assert property (@(posedge clk_in) disable iff (rst_N_in)
    wb.valid |-> ring[wb.rob_ptr].status == ST_ISSUED)
    else $error("writeback to entry %0d which is not issued", wb.rob_ptr);

endmodule

`default_nettype wire

// ==== rob_scheduler.sv ====
`timescale 1ns/1ns
`default_nettype none

module rob_scheduler
  import uop_pkg::*;
  import rob_pkg::*;
#(
  parameter int ROB_DEPTH = 8
) (
  input  logic                       clk_in,
  input  logic                       rst_N_in,
  input  rob_entry_t [ROB_DEPTH-1:0] entries,
  input  rob_ptr_t                   head,
  input  logic       [ROB_PTR_W:0]   count,
  output logic [3:0][PREG_W-1:0]     rd_addr,   // 0,1 alu sources; 2,3 mul sources
  input  logic [3:0][DATA_W-1:0]     rd_data,
  input  logic [3:0]                 src_ready,
  input  logic                       alu_busy,
  output issue_t                     alu_issue,
  output issue_t                     mul_issue,
  output mark_t                      alu_mark,
  output mark_t                      mul_mark,
  output logic                       retire,
  output commit_t                    commit_out
);

  logic       alu_found, mul_found;
  rob_ptr_t   alu_idx, mul_idx;
  rob_entry_t alu_cand, mul_cand;
  logic       alu_ok, mul_ok;

  function automatic rob_ptr_t ptr_add(rob_ptr_t base, int unsigned offs);
    int unsigned sum;
    sum = base + offs;
    if (sum >= ROB_DEPTH) begin
      sum = sum - ROB_DEPTH;
    end
    return rob_ptr_t'(sum);
  endfunction

  function automatic issue_t make_issue(rob_ptr_t ptr, uop_t u, logic [DATA_W-1:0] a,
                                        logic [DATA_W-1:0] b);
    issue_t iss;
    iss.valid   = 1'b1;
    iss.rob_ptr = ptr;
    iss.opcode  = u.opcode;
    iss.dest    = u.dest;
    iss.a       = a;
    iss.b       = b;
    iss.imm     = u.imm;
    return iss;
  endfunction

  // walk from head, first waiting uop of each class wins
  always_comb begin
    alu_found = 1'b0;
    mul_found = 1'b0;
    alu_idx   = '0;
    mul_idx   = '0;
    for (int unsigned i = 0; i < ROB_DEPTH; i++) begin
      if (i < count && entries[ptr_add(head, i)].status == ST_READY) begin
        if (entries[ptr_add(head, i)].uop.opcode == OP_MUL) begin
          if (!mul_found) begin
            mul_found = 1'b1;
            mul_idx   = ptr_add(head, i);
          end
        end else if (!alu_found) begin
          alu_found = 1'b1;
          alu_idx   = ptr_add(head, i);
        end
      end
    end
  end

  assign alu_cand = entries[alu_idx];
  assign mul_cand = entries[mul_idx];

  assign rd_addr[0] = alu_cand.uop.src1;
  assign rd_addr[1] = alu_cand.uop.src2;
  assign rd_addr[2] = mul_cand.uop.src1;
  assign rd_addr[3] = mul_cand.uop.src2;

  // li has no register sources
  assign alu_ok = alu_found && !alu_busy &&
                  (alu_cand.uop.opcode == OP_LI || (src_ready[0] && src_ready[1]));
  assign mul_ok = mul_found && src_ready[2] && src_ready[3];

  assign alu_mark = '{valid: alu_ok, ptr: alu_idx};
  assign mul_mark = '{valid: mul_ok, ptr: mul_idx};

  assign retire = (count != '0) && (entries[head].status == ST_DONE);

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      alu_issue  <= '0;
      mul_issue  <= '0;
      commit_out <= '0;
    end else begin
      if (!alu_busy) begin  // held issue waits for the alu result slot
        alu_issue <= alu_ok ? make_issue(alu_idx, alu_cand.uop, rd_data[0], rd_data[1]) : '0;
      end
      mul_issue <= mul_ok ? make_issue(mul_idx, mul_cand.uop, rd_data[2], rd_data[3]) : '0;
      if (retire) begin
        commit_out <= '{valid: 1'b1, rob_ptr: head, dest: entries[head].uop.dest,
                        data: entries[head].result};
      end else begin
        commit_out <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_rob_backend.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_rob_backend
  import uop_pkg::*;
  import rob_pkg::*;
;

  localparam int ROB_DEPTH     = 8;
  localparam int NUM_PREGS     = 32;
  localparam int READY_TIMEOUT = 100;  // cycles a dispatch may wait for rob_ready
  localparam int DRAIN_TIMEOUT = 300;

  logic    clk_in;
  logic    rst_N_in;
  uop_t    dispatch_in;
  logic    rob_ready;
  commit_t commit_out;

  commit_t     exp_q[$];  // expected commits in program order
  int          value_errors;
  int          other_errors;
  int          dispatched;
  logic        timed_out;
  logic [31:0] lfsr;

  rob_backend_top #(.ROB_DEPTH(ROB_DEPTH), .NUM_PREGS(NUM_PREGS)) uut (
    .clk_in(clk_in), .rst_N_in(rst_N_in), .dispatch_in(dispatch_in),
    .rob_ready(rob_ready), .commit_out(commit_out)
  );

  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in;
  end

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bit(output logic b);
    b    = lfsr[0];
    lfsr = lfsr_step(lfsr);
  endtask

  task automatic check_commit(input commit_t got, input commit_t exp);
    if (got.rob_ptr !== exp.rob_ptr) begin
      value_errors++;
      $display("[ERROR] commit_out.rob_ptr got %h expected %h", got.rob_ptr, exp.rob_ptr);
    end
    if (got.dest !== exp.dest) begin
      value_errors++;
      $display("[ERROR] commit_out.dest got %h expected %h", got.dest, exp.dest);
    end
    if (got.data !== exp.data) begin
      value_errors++;
      $display("[ERROR] commit_out.data got %h expected %h", got.data, exp.data);
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] rob_ready got %h expected %h", got, exp);
    end
  endtask

  // one idle cycle count of 0..3 from two lfsr bits
  task automatic idle_gap();
    logic b0;
    logic b1;
    take_bit(b0);
    take_bit(b1);
    repeat ({b1, b0}) begin
      @(posedge clk_in);
      #1;
    end
  endtask

  task automatic dispatch_uop(input uop_t u, input commit_t exp);
    int waited;
    waited = 0;
    while (!rob_ready && waited < READY_TIMEOUT) begin  // hold dispatch while full
      @(posedge clk_in);
      #1;
      waited++;
    end
    if (!rob_ready) begin
      other_errors++;
      timed_out = 1'b1;
      $display("rob_ready stayed low for %0d cycles, dispatch gave up", waited);
    end else begin
      exp_q.push_back(exp);
      dispatch_in = u;
      @(posedge clk_in);
      #1;
      dispatch_in = '0;
      dispatched++;
    end
  endtask

  task automatic run_stimulus();
    int          fd;
    int          n;
    string       line;
    byte         kind;
    logic [31:0] op, dest, s1, s2, imm, edest, edata;
    int          gap;
    int          cycles;
    uop_t        u;
    commit_t     exp;
    fd = $fopen("rob_backend_stim.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open rob_backend_stim.txt");
      return;
    end
    while (!$feof(fd) && !timed_out) begin
      line = "";
      if ($fgets(line, fd) == 0) begin
        continue;
      end
      n = $sscanf(line, "%c", kind);
      if (n != 1) begin
        continue;
      end
      if (kind == "U") begin
        n = $sscanf(line, "%c %h %h %h %h %h %h %h %d", kind, op, dest, s1, s2, imm,
                    edest, edata, gap);
        if (n != 9) begin
          other_errors++;
          $display("badly formed uop line in stimulus file: %s", line);
          continue;
        end
        if (gap != 0) begin
          idle_gap();
        end
        u.valid  = 1'b1;
        u.opcode = opcode_e'(op[2:0]);
        u.dest   = dest[PREG_W-1:0];
        u.src1   = s1[PREG_W-1:0];
        u.src2   = s2[PREG_W-1:0];
        u.imm    = imm[IMM_W-1:0];
        exp.valid   = 1'b1;
        exp.rob_ptr = rob_ptr_t'(dispatched % ROB_DEPTH);  // ring fills from slot 0
        exp.dest    = edest[PREG_W-1:0];
        exp.data    = edata;
        dispatch_uop(u, exp);
      end else if (kind == "F") begin
        check_ready(rob_ready, 1'b0);
      end else if (kind == "W") begin
        n = $sscanf(line, "%c %d", kind, cycles);
        repeat (cycles) begin
          @(posedge clk_in);
          #1;
        end
      end
    end
    $fclose(fd);
  endtask

  // commit_out is registered, so the falling edge sees it settled
  always @(negedge clk_in) begin
    if (!rst_N_in && commit_out.valid) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("commit of p%0d seen with no uop left to commit", commit_out.dest);
      end else begin
        check_commit(commit_out, exp_q.pop_front());
      end
    end
  end

  initial begin
    int waited;
    rst_N_in     = 1'b1;
    dispatch_in  = '0;
    value_errors = 0;
    other_errors = 0;
    dispatched   = 0;
    timed_out    = 1'b0;
    lfsr         = 32'h3404;
    repeat (8) @(posedge clk_in);
    #1;
    rst_N_in = 1'b0;
    check_ready(rob_ready, 1'b1);
    repeat (4) begin  // quiet queue, the monitor flags any stray commit
      @(posedge clk_in);
      #1;
    end
    check_ready(rob_ready, 1'b1);
    run_stimulus();
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(posedge clk_in);
      #1;
      waited++;
    end
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("%0d commits still missing after %0d cycles", exp_q.size(), waited);
    end
    $display("value errors %0d, other errors %0d, uops dispatched %0d",
             value_errors, other_errors, dispatched);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== uop_pkg.sv ====
`default_nettype none

package uop_pkg;

  localparam int DATA_W = 32;  // operand and result width
  localparam int PREG_W = 5;   // physical register index
  localparam int IMM_W  = 16;

  // uop opcodes, OP_MUL is the only one routed to the multiplier
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_XOR = 3'd3,
    OP_LI  = 3'd4,  // dest = zero-extended imm
    OP_MUL = 3'd5
  } opcode_e;

  // renamed uop as it arrives from dispatch
  typedef struct packed {
    logic              valid;
    opcode_e           opcode;
    logic [PREG_W-1:0] dest;
    logic [PREG_W-1:0] src1;
    logic [PREG_W-1:0] src2;
    logic [IMM_W-1:0]  imm;
  } uop_t;

endpackage

`default_nettype wire

// ==== wb_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_arbiter
  import rob_pkg::*;
(
  input  wb_t  alu_req,
  input  wb_t  mul_req,
  output logic alu_grant,
  output wb_t  wb_bus
);

  // multiplier pipeline cannot stall, so it always wins
  assign alu_grant = alu_req.valid && !mul_req.valid;

  always_comb begin
    if (mul_req.valid) begin
      wb_bus = mul_req;
    end else if (alu_grant) begin
      wb_bus = alu_req;
    end else begin
      wb_bus = '0;
    end
  end

endmodule

`default_nettype wire
